// ==== common/lpif_params.svh ====
////////////////////////////////////////////////////////////////////////////
// LPIF link widths and lane bit positions
// Shared by the package and the lane mapper
////////////////////////////////////////////////////////////////////////////

`ifndef LPIF_PARAMS_SVH
`define LPIF_PARAMS_SVH

// Full flit as seen by the user side
`define LPIF_FLIT_WIDTH 75

// One PHY lane word
`define LPIF_LANE_WIDTH 40

// Flit bits carried below the strobe bit
`define LPIF_LANE_PAYLOAD 38

// Sideband bits at the top of each lane word
`define LPIF_MARKER_BIT 39
`define LPIF_STROBE_BIT 38

// Bring-up delay counters
`define LPIF_DELAY_WIDTH 16

`endif

// ==== common/lpif_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// LPIF link types
// Flit, lane word, user field, delay and bring-up state types
////////////////////////////////////////////////////////////////////////////

`include "lpif_params.svh"

package lpif_pkg;

  // Packed flit, top down
  // state 4, protid 2, data 64, dvalid 1, crc 2, crc_valid 1, valid 1
  typedef logic [`LPIF_FLIT_WIDTH-1:0] flit_t;

  // One word on a PHY lane
  // marker on top, then strobe, then payload
  typedef logic [`LPIF_LANE_WIDTH-1:0] lane_word_t;

  // User side fields
  typedef logic [3:0] link_state_t;
  typedef logic [1:0] protid_t;
  typedef logic [1:0] crc_t;

  // Cycle count for the bring-up waits
  typedef logic [`LPIF_DELAY_WIDTH-1:0] delay_t;

  // Debug word
  // bit 19 tx online, bit 18 rx online, 15:0 rx valid flit count
  typedef logic [31:0] debug_status_t;

  // Transmit bring-up
  typedef enum logic [1:0] {
    SYNC_IDLE,
    SYNC_MARK,
    SYNC_ONLINE
  } sync_state_t;

endpackage

// ==== common/link_sync_if.sv ====
`timescale 1ns/1ps

////////////////////////////////////////////////////////////////////////////
// Link bring-up status from the sync block to the datapath blocks
////////////////////////////////////////////////////////////////////////////

interface link_sync_if;

  // Marker phase or online
  logic tx_active;

  // Transmit side declared online
  logic tx_online_delay;

  // Strobe value for the lane words
  logic strobe_bit;

  // Receive side declared online
  logic rx_online_delay;

  // Driven by the bring-up FSM
  modport sync (
    output tx_active,
    output tx_online_delay,
    output strobe_bit,
    output rx_online_delay
  );

  // Read by lane mapper and flit codec
  modport lane (
    input tx_active,
    input tx_online_delay,
    input strobe_bit,
    input rx_online_delay
  );

endinterface

// ==== sync/link_sync.sv ====
`timescale 1ns/1ps

////////////////////////////////////////////////////////////////////////////
// Link bring-up
// Sends markers for a set time before transmit online, qualifies receive
////////////////////////////////////////////////////////////////////////////

module link_sync (
  input  logic             clk_wr,
  input  logic             reset,
  input  logic             tx_online,
  input  logic             rx_online,
  input  lpif_pkg::delay_t delay_x_value,
  input  lpif_pkg::delay_t delay_y_value,
  input  logic             tx_stb_userbit,
  input  logic             rx_marker,
  link_sync_if.sync        sync
);

  import lpif_pkg::*;

  sync_state_t state;
  sync_state_t state_next;
  delay_t      tx_count;
  delay_t      rx_count;
  logic        mark_done;
  logic        rx_qualified;
  logic        rx_online_delay_q;

  //////////////////////////////////////////////////////////////////////////
  // Transmit side

  // Last cycle of the marker phase
  // one extra bit so the compare never wraps
  assign mark_done = ({1'b0, tx_count} + 1'b1) >= {1'b0, delay_x_value};

  always_comb begin
    state_next = state;
    case (state)
      SYNC_IDLE: begin
        if (tx_online) begin
          state_next = SYNC_MARK;
        end
      end
      SYNC_MARK: begin
        if (!tx_online) begin
          state_next = SYNC_IDLE;
        end else if (mark_done) begin
          state_next = SYNC_ONLINE;
        end
      end
      SYNC_ONLINE: begin
        if (!tx_online) begin
          state_next = SYNC_IDLE;
        end
      end
      default: begin
        state_next = SYNC_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      state    <= SYNC_IDLE;
      tx_count <= '0;
    end else begin
      state <= state_next;
      // Count only while the marker phase continues
      if (state == SYNC_MARK && state_next == SYNC_MARK) begin
        tx_count <= tx_count + 1'b1;
      end else begin
        tx_count <= '0;
      end
    end
  end

  assign sync.tx_active       = (state != SYNC_IDLE);
  assign sync.tx_online_delay = (state == SYNC_ONLINE);
  // Forced strobe while marking, user strobe once online
  assign sync.strobe_bit      = (state == SYNC_MARK) ||
                                ((state == SYNC_ONLINE) && tx_stb_userbit);

  //////////////////////////////////////////////////////////////////////////
  // Receive side

  // Far end online and its marker seen on both lanes
  assign rx_qualified = rx_online && rx_marker;

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      rx_count          <= '0;
      rx_online_delay_q <= 1'b0;
    end else if (!rx_qualified) begin
      // Lost qualification restarts the wait
      rx_count          <= '0;
      rx_online_delay_q <= 1'b0;
    end else if (rx_count >= delay_y_value) begin
      rx_online_delay_q <= 1'b1;
    end else begin
      rx_count <= rx_count + 1'b1;
    end
  end

  assign sync.rx_online_delay = rx_online_delay_q;

  //////////////////////////////////////////////////////////////////////////
  // Checks

  // Online only while tx_online was held on the cycle before
  assert property (@(posedge clk_wr) disable iff (reset)
    sync.tx_online_delay |-> sync.tx_active && $past(tx_online));

  // Receive online follows the far end going away
  assert property (@(posedge clk_wr) disable iff (reset)
    !rx_online |=> !sync.rx_online_delay);

endmodule

// ==== lane/lane_mapper.sv ====
`timescale 1ns/1ps

////////////////////////////////////////////////////////////////////////////
// Lane mapper
// Splits a flit over two PHY lanes and joins received lanes back
////////////////////////////////////////////////////////////////////////////

`include "lpif_params.svh"

module lane_mapper (
  input  logic                 clk_wr,
  input  logic                 reset,
  link_sync_if.lane            sync,
  input  lpif_pkg::flit_t      tx_flit,
  output lpif_pkg::lane_word_t tx_phy0,
  output lpif_pkg::lane_word_t tx_phy1,
  input  lpif_pkg::lane_word_t rx_phy0,
  input  lpif_pkg::lane_word_t rx_phy1,
  output lpif_pkg::flit_t      rx_flit,
  output logic                 rx_marker
);

  import lpif_pkg::*;

  // Flit bits that go to lane 1
  localparam int HI_BITS = `LPIF_FLIT_WIDTH - `LPIF_LANE_PAYLOAD;

  logic [`LPIF_LANE_PAYLOAD-1:0] payload0;
  logic [`LPIF_LANE_PAYLOAD-1:0] payload1;
  lane_word_t                    rx_word0;
  lane_word_t                    rx_word1;

  // Sideband bits on top, payload only once online
  function automatic lane_word_t build_lane(
    input logic [`LPIF_LANE_PAYLOAD-1:0] payload,
    input logic                          marker,
    input logic                          strobe,
    input logic                          online
  );
    lane_word_t word;
    word = '0;
    word[`LPIF_MARKER_BIT] = marker;
    word[`LPIF_STROBE_BIT] = strobe;
    if (online) begin
      word[`LPIF_LANE_PAYLOAD-1:0] = payload;
    end
    return word;
  endfunction

  //////////////////////////////////////////////////////////////////////////
  // Transmit

  // Low flit bits on lane 0
  assign payload0 = tx_flit[`LPIF_LANE_PAYLOAD-1:0];
  // High flit bits on lane 1, top payload bit unused
  assign payload1 = {{(`LPIF_LANE_PAYLOAD-HI_BITS){1'b0}},
                     tx_flit[`LPIF_FLIT_WIDTH-1:`LPIF_LANE_PAYLOAD]};

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      tx_phy0 <= '0;
      tx_phy1 <= '0;
    end else begin
      tx_phy0 <= build_lane(payload0, sync.tx_active, sync.strobe_bit,
                            sync.tx_online_delay);
      tx_phy1 <= build_lane(payload1, sync.tx_active, sync.strobe_bit,
                            sync.tx_online_delay);
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Receive

  // Capture both lanes on the same edge
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      rx_word0 <= '0;
      rx_word1 <= '0;
    end else begin
      rx_word0 <= rx_phy0;
      rx_word1 <= rx_phy1;
    end
  end

  assign rx_flit = {rx_word1[HI_BITS-1:0], rx_word0[`LPIF_LANE_PAYLOAD-1:0]};

  // Marker counts only when seen on both lanes
  assign rx_marker = rx_word0[`LPIF_MARKER_BIT] & rx_word1[`LPIF_MARKER_BIT];

  // Lanes stay aligned once the receive side is up
  assert property (@(posedge clk_wr) disable iff (reset)
    sync.rx_online_delay |-> (rx_word0[`LPIF_MARKER_BIT] == rx_word1[`LPIF_MARKER_BIT]));

endmodule

// ==== logic/flit_codec.sv ====
`timescale 1ns/1ps

////////////////////////////////////////////////////////////////////////////
// Flit codec
// Packs upstream fields, unpacks received flits, keeps debug status
////////////////////////////////////////////////////////////////////////////

module flit_codec (
  input  logic                    clk_wr,
  input  logic                    reset,
  link_sync_if.lane               sync,
  input  lpif_pkg::link_state_t   ustrm_state,
  input  lpif_pkg::protid_t       ustrm_protid,
  input  logic [63:0]             ustrm_data,
  input  logic                    ustrm_dvalid,
  input  lpif_pkg::crc_t          ustrm_crc,
  input  logic                    ustrm_crc_valid,
  input  logic                    ustrm_valid,
  output lpif_pkg::flit_t         tx_flit,
  input  lpif_pkg::flit_t         rx_flit,
  output lpif_pkg::link_state_t   dstrm_state,
  output lpif_pkg::protid_t       dstrm_protid,
  output logic [63:0]             dstrm_data,
  output logic                    dstrm_dvalid,
  output lpif_pkg::crc_t          dstrm_crc,
  output logic                    dstrm_crc_valid,
  output logic                    dstrm_valid,
  output lpif_pkg::debug_status_t debug_status
);

  import lpif_pkg::*;

  // Received flit split into user fields
  link_state_t rx_state;
  protid_t     rx_protid;
  logic [63:0] rx_data;
  logic        rx_dvalid;
  crc_t        rx_crc;
  logic        rx_crc_valid;
  logic        rx_valid;

  // Valid flits delivered downstream
  logic [15:0] valid_count;

  //////////////////////////////////////////////////////////////////////////
  // Upstream

  // Field order fixed by the flit layout, state on top
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      tx_flit <= '0;
    end else begin
      tx_flit <= {ustrm_state, ustrm_protid, ustrm_data, ustrm_dvalid,
                  ustrm_crc, ustrm_crc_valid, ustrm_valid};
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Downstream

  assign {rx_state, rx_protid, rx_data, rx_dvalid,
          rx_crc, rx_crc_valid, rx_valid} = rx_flit;

  // Nothing passes until the receive side is online
  always_ff @(posedge clk_wr) begin
    if (reset || !sync.rx_online_delay) begin
      dstrm_state     <= '0;
      dstrm_protid    <= '0;
      dstrm_data      <= '0;
      dstrm_dvalid    <= 1'b0;
      dstrm_crc       <= '0;
      dstrm_crc_valid <= 1'b0;
      dstrm_valid     <= 1'b0;
    end else begin
      dstrm_state     <= rx_state;
      dstrm_protid    <= rx_protid;
      dstrm_data      <= rx_data;
      dstrm_dvalid    <= rx_dvalid;
      dstrm_crc       <= rx_crc;
      dstrm_crc_valid <= rx_crc_valid;
      dstrm_valid     <= rx_valid;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Debug status

  // Wraps at 16 bits
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      valid_count <= '0;
    end else if (dstrm_valid) begin
      valid_count <= valid_count + 1'b1;
    end
  end

  // Online bits at 19 and 18, count in the low half
  assign debug_status = {12'h000, sync.tx_online_delay, sync.rx_online_delay,
                         2'b00, valid_count};

  // A crc flag never shows without its flit
  assert property (@(posedge clk_wr) disable iff (reset)
    (!rx_crc_valid || rx_valid) |=> (!dstrm_crc_valid || dstrm_valid));

endmodule

// ==== logic/lpif_link_top.sv ====
`timescale 1ns/1ps

////////////////////////////////////////////////////////////////////////////
// LPIF x2 slave link top
// Bring-up, flit codec and lane mapper on one write clock
////////////////////////////////////////////////////////////////////////////

module lpif_link_top (
  input  logic                    clk_wr,
  input  logic                    reset,
  // Link control
  input  logic                    tx_online,
  input  logic                    rx_online,
  // PHY lanes
  output lpif_pkg::lane_word_t    tx_phy0,
  output lpif_pkg::lane_word_t    tx_phy1,
  input  lpif_pkg::lane_word_t    rx_phy0,
  input  lpif_pkg::lane_word_t    rx_phy1,
  // Upstream user fields
  input  lpif_pkg::link_state_t   ustrm_state,
  input  lpif_pkg::protid_t       ustrm_protid,
  input  logic [63:0]             ustrm_data,
  input  logic                    ustrm_dvalid,
  input  lpif_pkg::crc_t          ustrm_crc,
  input  logic                    ustrm_crc_valid,
  input  logic                    ustrm_valid,
  // Downstream user fields
  output lpif_pkg::link_state_t   dstrm_state,
  output lpif_pkg::protid_t       dstrm_protid,
  output logic [63:0]             dstrm_data,
  output logic                    dstrm_dvalid,
  output lpif_pkg::crc_t          dstrm_crc,
  output logic                    dstrm_crc_valid,
  output logic                    dstrm_valid,
  output lpif_pkg::debug_status_t debug_status,
  // Configuration
  input  logic                    tx_stb_userbit,
  input  lpif_pkg::delay_t        delay_x_value,
  input  lpif_pkg::delay_t        delay_y_value
);

  import lpif_pkg::*;

  flit_t tx_flit;
  flit_t rx_flit;
  logic  rx_marker;

  // Bring-up status to both datapath blocks
  link_sync_if link_sync_bus ();

  link_sync link_sync_inst (
    .clk_wr         (clk_wr),
    .reset          (reset),
    .tx_online      (tx_online),
    .rx_online      (rx_online),
    .delay_x_value  (delay_x_value),
    .delay_y_value  (delay_y_value),
    .tx_stb_userbit (tx_stb_userbit),
    .rx_marker      (rx_marker),
    .sync           (link_sync_bus.sync)
  );

  lane_mapper lane_mapper_inst (
    .clk_wr    (clk_wr),
    .reset     (reset),
    .sync      (link_sync_bus.lane),
    .tx_flit   (tx_flit),
    .tx_phy0   (tx_phy0),
    .tx_phy1   (tx_phy1),
    .rx_phy0   (rx_phy0),
    .rx_phy1   (rx_phy1),
    .rx_flit   (rx_flit),
    .rx_marker (rx_marker)
  );

  flit_codec flit_codec_inst (
    .clk_wr          (clk_wr),
    .reset           (reset),
    .sync            (link_sync_bus.lane),
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc       (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid),
    .ustrm_valid     (ustrm_valid),
    .tx_flit         (tx_flit),
    .rx_flit         (rx_flit),
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid     (dstrm_valid),
    .debug_status    (debug_status)
  );

endmodule

// ==== test/lpif_link_tb.sv ====
`timescale 1ns/1ps

////////////////////////////////////////////////////////////////////////////
// LPIF link testbench
// Loops both lanes back, checks bring-up, datapath and debug status
////////////////////////////////////////////////////////////////////////////

`include "lpif_params.svh"

module lpif_link_tb;

  import lpif_pkg::*;

  // User fields of one flit, in flit order
  typedef struct packed {
    link_state_t state;
    protid_t     protid;
    logic [63:0] data;
    logic        dvalid;
    crc_t        crc;
    logic        crc_valid;
    logic        valid;
  } fields_t;

  localparam int TABLE_LEN   = 24;
  localparam int PRE_LEN     = 8;
  localparam int DELAY_X     = 6;
  localparam int DELAY_Y     = 3;
  // ustrm to dstrm through the loopback
  localparam int PIPE_DEPTH  = 4;
  localparam int CYCLE_LIMIT = 4 * TABLE_LEN + DELAY_X + DELAY_Y + 50;

  logic          clk_wr;
  logic          reset;
  logic          tx_online;
  logic          rx_online;
  lane_word_t    tx_phy0;
  lane_word_t    tx_phy1;
  lane_word_t    rx_phy0;
  lane_word_t    rx_phy1;
  link_state_t   ustrm_state;
  protid_t       ustrm_protid;
  logic [63:0]   ustrm_data;
  logic          ustrm_dvalid;
  crc_t          ustrm_crc;
  logic          ustrm_crc_valid;
  logic          ustrm_valid;
  link_state_t   dstrm_state;
  protid_t       dstrm_protid;
  logic [63:0]   dstrm_data;
  logic          dstrm_dvalid;
  crc_t          dstrm_crc;
  logic          dstrm_crc_valid;
  logic          dstrm_valid;
  debug_status_t debug_status;
  logic          tx_stb_userbit;
  delay_t        delay_x_value;
  delay_t        delay_y_value;

  // Loopback held open until reset is released
  logic          loop_closed;

  // Stimulus and expected values
  logic [10:0]   table_ctrl [0:TABLE_LEN-1];
  fields_t       stim [0:TABLE_LEN-1];
  fields_t       pre_item [0:PRE_LEN-1];
  fields_t       exp_q [$];
  int            errors;
  int            checks;
  int            cycle_count;

  lpif_link_top lpif_link_top_inst (
    .clk_wr          (clk_wr),
    .reset           (reset),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .tx_phy0         (tx_phy0),
    .tx_phy1         (tx_phy1),
    .rx_phy0         (rx_phy0),
    .rx_phy1         (rx_phy1),
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc       (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid),
    .ustrm_valid     (ustrm_valid),
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid     (dstrm_valid),
    .debug_status    (debug_status),
    .tx_stb_userbit  (tx_stb_userbit),
    .delay_x_value   (delay_x_value),
    .delay_y_value   (delay_y_value)
  );

  // Lane 0 back to lane 0, lane 1 back to lane 1
  assign rx_phy0 = loop_closed ? tx_phy0 : '0;
  assign rx_phy1 = loop_closed ? tx_phy1 : '0;

  initial begin
    clk_wr = 1'b0;
    forever #4 clk_wr = ~clk_wr;
  end

  // Run limit
  initial begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge clk_wr);
      cycle_count++;
    end
    $display("Timeout: run still going after %0d cycles", CYCLE_LIMIT);
    $display("Result: FAILED");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////////
  // Expected value helpers

  // State on top, valid at bit 0
  function automatic flit_t pack_fields(input fields_t f);
    return {f.state, f.protid, f.data, f.dvalid, f.crc, f.crc_valid, f.valid};
  endfunction

  // Marker and strobe above the payload
  function automatic lane_word_t make_lane(
    input logic [`LPIF_LANE_PAYLOAD-1:0] payload,
    input logic                          marker,
    input logic                          strobe
  );
    lane_word_t w;
    w = '0;
    w[`LPIF_MARKER_BIT] = marker;
    w[`LPIF_STROBE_BIT] = strobe;
    w[`LPIF_LANE_PAYLOAD-1:0] = payload;
    return w;
  endfunction

  function automatic debug_status_t make_status(
    input logic        tx_on,
    input logic        rx_on,
    input logic [15:0] count
  );
    debug_status_t s;
    s = '0;
    s[19] = tx_on;
    s[18] = rx_on;
    s[15:0] = count;
    return s;
  endfunction

  // Random fields, always a valid flit
  function automatic fields_t random_fields();
    logic [31:0] r;
    fields_t     f;
    r = $urandom;
    f.state     = r[3:0];
    f.protid    = r[5:4];
    f.dvalid    = r[6];
    f.crc       = r[8:7];
    f.crc_valid = r[9];
    f.valid     = 1'b1;
    f.data      = {$urandom, $urandom};
    return f;
  endfunction

  //////////////////////////////////////////////////////////////////////////
  // Compare tasks

  task automatic report_mismatch(input string name, input logic [74:0] exp,
                                 input logic [74:0] got);
    errors++;
    $display("Mismatch at %0t: %s expected %0h got %0h", $time, name, exp, got);
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("Error at %0t: %s", $time, what);
  endtask

  task automatic check_flit_fields(input fields_t exp);
    checks++;
    if (dstrm_state !== exp.state) report_mismatch("dstrm_state", exp.state, dstrm_state);
    if (dstrm_protid !== exp.protid) report_mismatch("dstrm_protid", exp.protid, dstrm_protid);
    if (dstrm_data !== exp.data) report_mismatch("dstrm_data", exp.data, dstrm_data);
    if (dstrm_dvalid !== exp.dvalid) report_mismatch("dstrm_dvalid", exp.dvalid, dstrm_dvalid);
    if (dstrm_crc !== exp.crc) report_mismatch("dstrm_crc", exp.crc, dstrm_crc);
    if (dstrm_crc_valid !== exp.crc_valid) begin
      report_mismatch("dstrm_crc_valid", exp.crc_valid, dstrm_crc_valid);
    end
    if (dstrm_valid !== exp.valid) report_mismatch("dstrm_valid", exp.valid, dstrm_valid);
  endtask

  task automatic check_lane(input string name, input lane_word_t exp, input lane_word_t got);
    checks++;
    if (got !== exp) report_mismatch(name, exp, got);
  endtask

  task automatic check_status(input debug_status_t exp);
    checks++;
    if (debug_status !== exp) report_mismatch("debug_status", exp, debug_status);
  endtask

  // Called right after a rising edge
  task automatic drive_fields(input fields_t f);
    ustrm_state     <= f.state;
    ustrm_protid    <= f.protid;
    ustrm_data      <= f.data;
    ustrm_dvalid    <= f.dvalid;
    ustrm_crc       <= f.crc;
    ustrm_crc_valid <= f.crc_valid;
    ustrm_valid     <= f.valid;
  endtask

  // Columns: state, protid, dvalid, crc, crc_valid, valid
  task automatic load_table();
    table_ctrl[0]  = {4'h1, 2'd0, 1'b1, 2'd0, 1'b0, 1'b1};
    table_ctrl[1]  = {4'h2, 2'd1, 1'b1, 2'd1, 1'b1, 1'b1};
    table_ctrl[2]  = {4'h3, 2'd2, 1'b0, 2'd2, 1'b0, 1'b0};
    table_ctrl[3]  = {4'h4, 2'd3, 1'b1, 2'd3, 1'b1, 1'b1};
    table_ctrl[4]  = {4'h5, 2'd0, 1'b0, 2'd0, 1'b0, 1'b1};
    table_ctrl[5]  = {4'h6, 2'd1, 1'b1, 2'd2, 1'b0, 1'b0};
    table_ctrl[6]  = {4'h7, 2'd2, 1'b1, 2'd1, 1'b1, 1'b1};
    table_ctrl[7]  = {4'h8, 2'd3, 1'b0, 2'd3, 1'b0, 1'b1};
    table_ctrl[8]  = {4'h9, 2'd0, 1'b1, 2'd2, 1'b1, 1'b1};
    table_ctrl[9]  = {4'hA, 2'd1, 1'b0, 2'd0, 1'b0, 1'b0};
    table_ctrl[10] = {4'hB, 2'd2, 1'b1, 2'd3, 1'b1, 1'b1};
    table_ctrl[11] = {4'hC, 2'd3, 1'b1, 2'd1, 1'b0, 1'b1};
    table_ctrl[12] = {4'hD, 2'd0, 1'b0, 2'd2, 1'b0, 1'b0};
    table_ctrl[13] = {4'hE, 2'd1, 1'b1, 2'd0, 1'b1, 1'b1};
    table_ctrl[14] = {4'hF, 2'd2, 1'b1, 2'd3, 1'b0, 1'b1};
    table_ctrl[15] = {4'h0, 2'd3, 1'b0, 2'd1, 1'b1, 1'b1};
    table_ctrl[16] = {4'h1, 2'd1, 1'b1, 2'd2, 1'b0, 1'b0};
    table_ctrl[17] = {4'h3, 2'd2, 1'b1, 2'd0, 1'b1, 1'b1};
    table_ctrl[18] = {4'h5, 2'd3, 1'b0, 2'd3, 1'b0, 1'b1};
    table_ctrl[19] = {4'h7, 2'd0, 1'b1, 2'd1, 1'b1, 1'b1};
    table_ctrl[20] = {4'h9, 2'd1, 1'b0, 2'd2, 1'b0, 1'b0};
    table_ctrl[21] = {4'hB, 2'd2, 1'b1, 2'd3, 1'b1, 1'b1};
    table_ctrl[22] = {4'hD, 2'd3, 1'b1, 2'd0, 1'b0, 1'b1};
    table_ctrl[23] = {4'hF, 2'd0, 1'b1, 2'd1, 1'b1, 1'b1};
    for (int i = 0; i < TABLE_LEN; i++) begin
      stim[i] = {table_ctrl[i][10:5], {$urandom, $urandom}, table_ctrl[i][4:0]};
    end
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Test sequence

  initial begin
    fields_t     idle;
    fields_t     cur;
    fields_t     exp_item;
    flit_t       flit;
    logic [31:0] seed_val;
    int          n_valid;
    logic        reached;

    reset           = 1'b1;
    tx_online       = 1'b0;
    rx_online       = 1'b0;
    tx_stb_userbit  = 1'b0;
    delay_x_value   = delay_t'(DELAY_X);
    delay_y_value   = delay_t'(DELAY_Y);
    loop_closed     = 1'b0;
    ustrm_state     = '0;
    ustrm_protid    = '0;
    ustrm_data      = '0;
    ustrm_dvalid    = 1'b0;
    ustrm_crc       = '0;
    ustrm_crc_valid = 1'b0;
    ustrm_valid     = 1'b0;
    errors          = 0;
    checks          = 0;
    idle            = '0;

    seed_val = $urandom(59);
    load_table();
    for (int i = 0; i < PRE_LEN; i++) begin
      pre_item[i] = random_fields();
    end
    n_valid = 0;
    for (int i = 0; i < TABLE_LEN; i++) begin
      if (stim[i].valid) n_valid++;
    end

    // Reset for 5 cycles, then everything quiet
    repeat (5) @(posedge clk_wr);
    reset       <= 1'b0;
    loop_closed <= 1'b1;
    @(negedge clk_wr);
    check_flit_fields(idle);
    check_lane("tx_phy0", '0, tx_phy0);
    check_lane("tx_phy1", '0, tx_phy1);
    check_status(make_status(1'b0, 1'b0, 16'd0));

    ////////////////////////////////////////////////////////////////////////
    // Transmit bring-up, markers with forced strobe

    @(posedge clk_wr);
    tx_online <= 1'b1;
    reached = 1'b0;
    for (int c = 1; c <= DELAY_X + 2 && !reached; c++) begin
      @(posedge clk_wr);
      @(negedge clk_wr);
      if (debug_status[19]) begin
        reached = 1'b1;
        // Marker phase lasts delay_x_value cycles once out of idle
        if (c <= DELAY_X) begin
          report_failure("transmit side online before the marker phase ended");
        end
      end else begin
        check_status(make_status(1'b0, 1'b0, 16'd0));
        // Lane words lag the FSM by one register
        if (c >= 2) begin
          check_lane("tx_phy0", make_lane('0, 1'b1, 1'b1), tx_phy0);
          check_lane("tx_phy1", make_lane('0, 1'b1, 1'b1), tx_phy1);
        end
      end
    end
    if (!reached) report_failure("transmit side not online within delay_x_value plus 2");

    // Online now, strobe from the user bit
    @(posedge clk_wr);
    @(negedge clk_wr);
    check_lane("tx_phy0", make_lane('0, 1'b1, 1'b0), tx_phy0);
    check_lane("tx_phy1", make_lane('0, 1'b1, 1'b0), tx_phy1);

    ////////////////////////////////////////////////////////////////////////
    // Data on the lanes while rx_online is low

    for (int k = 0; k < PRE_LEN; k++) begin
      @(posedge clk_wr);
      tx_stb_userbit <= 1'b1;
      drive_fields(pre_item[k]);
      @(negedge clk_wr);
      check_flit_fields(idle);
      check_status(make_status(1'b1, 1'b0, 16'd0));
      // Two registers from ustrm to the lanes
      if (k >= 2) begin
        flit = pack_fields(pre_item[k-2]);
        check_lane("tx_phy0", make_lane(flit[`LPIF_LANE_PAYLOAD-1:0], 1'b1, 1'b1),
                   tx_phy0);
        check_lane("tx_phy1",
                   make_lane({1'b0, flit[`LPIF_FLIT_WIDTH-1:`LPIF_LANE_PAYLOAD]}, 1'b1, 1'b1),
                   tx_phy1);
      end
    end

    ////////////////////////////////////////////////////////////////////////
    // Receive bring-up
    // Last flits still in flight while the receive wait runs

    @(posedge clk_wr);
    rx_online <= 1'b1;
    drive_fields(idle);
    reached = 1'b0;
    for (int c = 1; c <= DELAY_Y + 4 && !reached; c++) begin
      @(posedge clk_wr);
      @(negedge clk_wr);
      if (debug_status[18]) reached = 1'b1;
      check_flit_fields(idle);
    end
    if (!reached) report_failure("receive side never came online after rx_online rose");

    ////////////////////////////////////////////////////////////////////////
    // Table through the loopback

    exp_q.delete();
    for (int t = 0; t < TABLE_LEN + PIPE_DEPTH; t++) begin
      @(posedge clk_wr);
      if (t < TABLE_LEN) begin
        cur = stim[t];
      end else begin
        cur = idle;
      end
      drive_fields(cur);
      exp_q.push_back(cur);
      @(negedge clk_wr);
      if (exp_q.size() > PIPE_DEPTH) begin
        exp_item = exp_q.pop_front();
        check_flit_fields(exp_item);
      end
    end

    // Count lags dstrm_valid by one edge
    @(posedge clk_wr);
    @(negedge clk_wr);
    check_status(make_status(1'b1, 1'b1, 16'(n_valid)));

    ////////////////////////////////////////////////////////////////////////
    // Link down

    @(posedge clk_wr);
    tx_online <= 1'b0;
    reached = 1'b0;
    for (int c = 1; c <= 4 && !reached; c++) begin
      @(posedge clk_wr);
      @(negedge clk_wr);
      if (debug_status[19:18] == 2'b00) reached = 1'b1;
    end
    if (!reached) report_failure("online bits still set 4 cycles after tx_online fell");
    check_lane("tx_phy0", '0, tx_phy0);
    check_lane("tx_phy1", '0, tx_phy1);
    check_status(make_status(1'b0, 1'b0, 16'(n_valid)));

    $display("Checks: %0d  Errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+common
common/lpif_pkg.sv
common/link_sync_if.sv
sync/link_sync.sv
lane/lane_mapper.sv
logic/flit_codec.sv
logic/lpif_link_top.sv
test/lpif_link_tb.sv
